/* verilog/ptw_pkg.sv */
/*
 * page table walker shared definitions
 * address widths, the miss queue entry, the configuration register,
 * the two views of a page table entry and the walk result, for a
 * two level 32-bit table with 8 KB pages and 8 byte entries
 */
package ptw_pkg;

	// ==============================
	// address geometry
	// ==============================

	localparam int PAGE_BITS = 13;
	// level 0 index sits just above the page offset
	localparam int L0_BITS = 10;
	// level 1 index takes the remaining top bits
	localparam int L1_BITS = 9;
	localparam int PTE_SHIFT = 3;

	typedef logic [31:0] vadr_t;
	typedef logic [31:0] padr_t;
	typedef logic [7:0] asid_t;
	typedef logic [5:0] rob_id_t;
	typedef logic [18:0] ppn_t;

	// ==============================
	// walker state
	// ==============================

	typedef struct packed {
		ppn_t base;
		logic lvl;
	} ptw_cfg_t;

	// one outstanding tlb miss
	typedef struct packed {
		logic v;
		logic cmt;
		logic lvl;
		asid_t asid;
		rob_id_t id;
		vadr_t adr;
		// address of the next table read
		padr_t tadr;
	} miss_entry_t;

	// ==============================
	// page table entry
	// ==============================

	// final translation, either a level 0 page or a level 1 superpage
	typedef struct packed {
		ppn_t ppn;
		logic [39:0] rsvd;
		logic x;
		logic w;
		logic r;
		logic s;
		logic v;
	} pte_leaf_t;

	// pointer to the next level table, s position is always zero
	typedef struct packed {
		ppn_t ppn;
		logic [42:0] rsvd;
		logic s0;
		logic v;
	} pte_dir_t;

	typedef union packed {
		pte_leaf_t leaf;
		pte_dir_t dir;
	} pte_t;

	typedef struct packed {
		logic fault;
		asid_t asid;
		vadr_t vadr;
		padr_t padr;
	} ptw_result_t;

	typedef struct packed {
		logic free;
		logic lvl;
		padr_t tadr;
	} walk_upd_t;

endpackage

/* verilog/ptw_config.sv */
/*
 * page table walker configuration register
 * holds the page table base page number and the root level that
 * new misses start their walk from
 */
`timescale 1ns/1ns

module ptw_config (
	input logic clk,
	input logic rst,
	input logic cfg_we,
	input ptw_pkg::ptw_cfg_t cfg_wdata,
	output ptw_pkg::ptw_cfg_t cfg
);

	// default is a two level table rooted at page zero
	always_ff @(posedge clk) begin
		if (rst) begin
			cfg.base <= '0;
			cfg.lvl <= 1'b1;
		end else if (cfg_we) begin
			cfg <= cfg_wdata;
		end
	end

endmodule

/* verilog/ptw_queue.sv */
/*
 * page table walker miss queue
 * stores tlb misses with their asid and reorder buffer id, refuses
 * duplicates, computes the first table address, marks commits,
 * drops flushed entries and applies walk step updates
 */
`timescale 1ns/1ns

module ptw_queue #(
	parameter int MISSQ_SIZE = 4
) (
	input logic clk,
	input logic rst,
	input ptw_pkg::ptw_cfg_t cfg,
	input logic miss_v,
	input ptw_pkg::asid_t miss_asid,
	input ptw_pkg::vadr_t miss_adr,
	input ptw_pkg::rob_id_t miss_id,
	input logic commit_v,
	input ptw_pkg::rob_id_t commit_id,
	input logic flush_v,
	input ptw_pkg::rob_id_t flush_id,
	input logic pte_v,
	input logic [$clog2(MISSQ_SIZE)-1:0] pte_tag,
	input ptw_pkg::walk_upd_t upd,
	output logic in_que,
	output ptw_pkg::miss_entry_t [MISSQ_SIZE-1:0] entries
);
	import ptw_pkg::*;

	localparam int TAG_W = $clog2(MISSQ_SIZE);

	typedef logic [TAG_W-1:0] tag_t;

	logic dup;
	logic have_free;
	tag_t free_idx;
	logic [L1_BITS-1:0] l1_idx;
	logic [L0_BITS-1:0] l0_idx;
	padr_t first_tadr;
	miss_entry_t new_entry;
	miss_entry_t cur;
	logic upd_ok;

	// ==============================
	// miss intake
	// ==============================

	// same asid and address already waiting
	always_comb begin
		dup = 1'b0;
		for (int i = 0; i < MISSQ_SIZE; i++) begin
			if (entries[i].v && entries[i].asid == miss_asid &&
				entries[i].adr == miss_adr) begin
				dup = 1'b1;
			end
		end
	end

	// scan downwards so the lowest free slot wins
	always_comb begin
		have_free = 1'b0;
		free_idx = '0;
		for (int i = MISSQ_SIZE - 1; i >= 0; i--) begin
			if (!entries[i].v) begin
				have_free = 1'b1;
				free_idx = tag_t'(i);
			end
		end
	end

	assign l1_idx = miss_adr[PAGE_BITS + L0_BITS +: L1_BITS];
	assign l0_idx = miss_adr[PAGE_BITS +: L0_BITS];

	// root table entry address, base plus index times pte size
	always_comb begin
		first_tadr = {cfg.base, {PAGE_BITS{1'b0}}};
		if (cfg.lvl) begin
			first_tadr = first_tadr + padr_t'({l1_idx, {PTE_SHIFT{1'b0}}});
		end else begin
			first_tadr = first_tadr + padr_t'({l0_idx, {PTE_SHIFT{1'b0}}});
		end
	end

	always_comb begin
		new_entry.v = 1'b1;
		new_entry.cmt = 1'b0;
		new_entry.lvl = cfg.lvl;
		new_entry.asid = miss_asid;
		new_entry.id = miss_id;
		new_entry.adr = miss_adr;
		new_entry.tadr = first_tadr;
	end

	// ==============================
	// walk response
	// ==============================

	// a response only lands on a live committed walk
	assign cur = entries[pte_tag];
	assign upd_ok = pte_v && cur.v && cur.cmt;

	always_ff @(posedge clk) begin
		if (rst) begin
			in_que <= 1'b0;
			for (int i = 0; i < MISSQ_SIZE; i++) begin
				entries[i].v <= 1'b0;
				entries[i].cmt <= 1'b0;
			end
		end else begin
			in_que <= miss_v && dup;

			// full queue drops the miss
			if (miss_v && !dup && have_free) begin
				entries[free_idx] <= new_entry;
			end

			for (int i = 0; i < MISSQ_SIZE; i++) begin
				if (commit_v && entries[i].v && entries[i].id == commit_id) begin
					entries[i].cmt <= 1'b1;
				end
			end

			if (upd_ok) begin
				if (upd.free) begin
					entries[pte_tag].v <= 1'b0;
					entries[pte_tag].cmt <= 1'b0;
				end else begin
					entries[pte_tag].lvl <= upd.lvl;
					entries[pte_tag].tadr <= upd.tadr;
				end
			end

			// flush comes last so it overrides commit and walk updates
			for (int i = 0; i < MISSQ_SIZE; i++) begin
				if (flush_v && entries[i].v && entries[i].id == flush_id) begin
					entries[i].v <= 1'b0;
					entries[i].cmt <= 1'b0;
				end
			end
		end
	end

endmodule

/* verilog/ptw_sched.sv */
/*
 * page table walker read scheduler
 * picks the lowest committed queue entry, issues its table read and
 * holds the single outstanding read until the response comes back
 */
`timescale 1ns/1ns

module ptw_sched #(
	parameter int MISSQ_SIZE = 4
) (
	input logic clk,
	input logic rst,
	input ptw_pkg::miss_entry_t [MISSQ_SIZE-1:0] entries,
	input logic pte_v,
	output logic walk_req,
	output logic [$clog2(MISSQ_SIZE)-1:0] walk_tag,
	output ptw_pkg::padr_t walk_adr,
	output logic busy
);

	localparam int TAG_W = $clog2(MISSQ_SIZE);

	typedef logic [TAG_W-1:0] tag_t;

	logic [MISSQ_SIZE-1:0] ready;
	logic ready_any;
	tag_t sel_idx;
	logic issue;

	always_comb begin
		for (int i = 0; i < MISSQ_SIZE; i++) begin
			ready[i] = entries[i].v && entries[i].cmt;
		end
	end

	// fixed priority, lowest index first
	always_comb begin
		sel_idx = '0;
		for (int i = MISSQ_SIZE - 1; i >= 0; i--) begin
			if (ready[i]) begin
				sel_idx = tag_t'(i);
			end
		end
	end

	assign ready_any = |ready;
	assign issue = !busy && !pte_v && ready_any;

	// ==============================
	// outstanding read
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			walk_req <= 1'b0;
		end else begin
			walk_req <= issue;
			if (pte_v) begin
				busy <= 1'b0;
			end else if (issue) begin
				busy <= 1'b1;
			end
		end
	end

	// tag stays put while the read is in flight
	always_ff @(posedge clk) begin
		if (issue) begin
			walk_tag <= sel_idx;
			walk_adr <= entries[sel_idx].tadr;
		end
	end

endmodule

/* verilog/ptw_step.sv */
/*
 * page table walker step logic
 * decodes a returned table entry as a leaf or directory, forms the
 * next level table address or the final physical address, and
 * registers the completion result
 */
`timescale 1ns/1ns

module ptw_step #(
	parameter int MISSQ_SIZE = 4
) (
	input logic clk,
	input logic rst,
	input ptw_pkg::miss_entry_t [MISSQ_SIZE-1:0] entries,
	input logic pte_v,
	input logic [$clog2(MISSQ_SIZE)-1:0] pte_tag,
	input ptw_pkg::pte_t pte,
	output ptw_pkg::walk_upd_t upd,
	output logic done,
	output ptw_pkg::ptw_result_t result
);
	import ptw_pkg::*;

	miss_entry_t cur;
	logic use_leaf;
	logic pte_ok;
	logic walk_end;
	padr_t leaf_padr;

	assign cur = entries[pte_tag];

	// only a level 1 entry with s clear points to another table
	assign use_leaf = !cur.lvl || pte.leaf.s;
	// valid sits in bit zero of both views
	assign pte_ok = pte.leaf.v;

	// ==============================
	// next state
	// ==============================

	always_comb begin
		upd.free = 1'b1;
		upd.lvl = cur.lvl;
		upd.tadr = cur.tadr;
		leaf_padr = '0;
		if (!pte_ok) begin
			// invalid entry ends the walk with a fault
			leaf_padr = '0;
		end else if (!use_leaf) begin
			upd.free = 1'b0;
			upd.lvl = 1'b0;
			upd.tadr = {pte.dir.ppn, cur.adr[PAGE_BITS +: L0_BITS], {PTE_SHIFT{1'b0}}};
		end else if (cur.lvl) begin
			// superpage keeps the level 0 index as part of the offset
			leaf_padr = {pte.leaf.ppn[$bits(ppn_t)-1 -: L1_BITS],
				cur.adr[PAGE_BITS + L0_BITS - 1:0]};
		end else begin
			leaf_padr = {pte.leaf.ppn, cur.adr[PAGE_BITS-1:0]};
		end
	end

	// same gating as the queue so a stale response reports nothing
	assign walk_end = pte_v && cur.v && cur.cmt && upd.free;

	// ==============================
	// completion
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			done <= 1'b0;
		end else begin
			done <= walk_end;
		end
	end

	always_ff @(posedge clk) begin
		if (walk_end) begin
			result.fault <= !pte_ok;
			result.asid <= cur.asid;
			result.vadr <= cur.adr;
			result.padr <= leaf_padr;
		end
	end

endmodule

/* verilog/ptw_top.sv */
/*
 * page table walker miss queue top level
 * ties the configuration register, miss queue, read scheduler and
 * step logic together
 */
`timescale 1ns/1ns

module ptw_top #(
	parameter int MISSQ_SIZE = 4
) (
	input logic clk,
	input logic rst,
	input logic cfg_we,
	input ptw_pkg::ptw_cfg_t cfg_wdata,
	input logic miss_v,
	input ptw_pkg::asid_t miss_asid,
	input ptw_pkg::vadr_t miss_adr,
	input ptw_pkg::rob_id_t miss_id,
	input logic commit_v,
	input ptw_pkg::rob_id_t commit_id,
	input logic flush_v,
	input ptw_pkg::rob_id_t flush_id,
	input logic pte_v,
	input logic [$clog2(MISSQ_SIZE)-1:0] pte_tag,
	input ptw_pkg::pte_t pte,
	output logic in_que,
	output logic walk_req,
	output logic [$clog2(MISSQ_SIZE)-1:0] walk_tag,
	output ptw_pkg::padr_t walk_adr,
	output logic done,
	output ptw_pkg::ptw_result_t result
);
	import ptw_pkg::*;

	ptw_cfg_t cfg;
	miss_entry_t [MISSQ_SIZE-1:0] entries;
	walk_upd_t upd;
	// high while a table read is in flight
	logic busy;

	ptw_config i_ptw_config (
		.clk (clk),
		.rst (rst),
		.cfg_we (cfg_we),
		.cfg_wdata (cfg_wdata),
		.cfg (cfg)
	);

	ptw_queue #(
		.MISSQ_SIZE (MISSQ_SIZE)
	) i_ptw_queue (
		.clk (clk),
		.rst (rst),
		.cfg (cfg),
		.miss_v (miss_v),
		.miss_asid (miss_asid),
		.miss_adr (miss_adr),
		.miss_id (miss_id),
		.commit_v (commit_v),
		.commit_id (commit_id),
		.flush_v (flush_v),
		.flush_id (flush_id),
		.pte_v (pte_v),
		.pte_tag (pte_tag),
		.upd (upd),
		.in_que (in_que),
		.entries (entries)
	);

	ptw_sched #(
		.MISSQ_SIZE (MISSQ_SIZE)
	) i_ptw_sched (
		.clk (clk),
		.rst (rst),
		.entries (entries),
		.pte_v (pte_v),
		.walk_req (walk_req),
		.walk_tag (walk_tag),
		.walk_adr (walk_adr),
		.busy (busy)
	);

	ptw_step #(
		.MISSQ_SIZE (MISSQ_SIZE)
	) i_ptw_step (
		.clk (clk),
		.rst (rst),
		.entries (entries),
		.pte_v (pte_v),
		.pte_tag (pte_tag),
		.pte (pte),
		.upd (upd),
		.done (done),
		.result (result)
	);

endmodule

/* bench/ptw_tb.sv */
/*
 * page table walker miss queue testbench
 * directed tests drive misses, commits, flushes and configuration,
 * answer table reads from a sparse memory and compare every read and
 * completion with a reference walk model
 */
`timescale 1ns/1ns

module ptw_tb;
	import ptw_pkg::*;

	localparam int MISSQ_SIZE = 4;
	localparam int TAG_W = $clog2(MISSQ_SIZE);
	localparam int CLK_NS = 8;
	localparam int N_TESTS = 5;
	// worst test, several walks with response delays
	localparam int TEST_CYCLES = 400;

	typedef logic [TAG_W-1:0] tag_t;

	logic clk = 1'b0;
	logic rst;
	logic cfg_we;
	ptw_cfg_t cfg_wdata;
	logic miss_v;
	asid_t miss_asid;
	vadr_t miss_adr;
	rob_id_t miss_id;
	logic commit_v;
	rob_id_t commit_id;
	logic flush_v;
	rob_id_t flush_id;
	logic pte_v;
	tag_t pte_tag;
	pte_t pte;
	logic in_que;
	logic walk_req;
	tag_t walk_tag;
	padr_t walk_adr;
	logic done;
	ptw_result_t result;

	// reference model of the queue and the table memory
	miss_entry_t mq [MISSQ_SIZE];
	ptw_cfg_t m_cfg;
	pte_t mem [padr_t];
	tag_t req_tag_q [$];
	padr_t req_adr_q [$];
	logic outstanding = 1'b0;
	logic [31:0] seed;
	int errors = 0;
	int checks = 0;
	int err_mark = 0;
	int n_tests = 0;
	int done_cnt = 0;
	int exp_done = 0;

	ptw_top #(.MISSQ_SIZE(MISSQ_SIZE)) i_ptw_top (.*);

	always #(CLK_NS / 2) clk = ~clk;

	initial begin
		#(N_TESTS * TEST_CYCLES * CLK_NS);
		$display("watchdog expired, the DUT stopped answering");
		$display("*** TEST FAILED ***");
		$finish;
	end

	// ==============================
	// bus monitor
	// ==============================

	// sampled mid cycle, away from the drive and capture edges
	always @(negedge clk) begin
		if (pte_v)
			outstanding = 1'b0;
		if (walk_req) begin
			if (outstanding) begin
				$display("%0t second table read issued while one is outstanding", $time);
				errors++;
			end
			outstanding = 1'b1;
			req_tag_q.push_back(walk_tag);
			req_adr_q.push_back(walk_adr);
		end
		if (done)
			done_cnt++;
	end

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("ERR %0t %s got %b exp %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_tag(input string name, input tag_t got, input tag_t exp);
		checks++;
		if (got !== exp) begin
			$display("ERR %0t %s got %h exp %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_padr(input string name, input padr_t got, input padr_t exp);
		checks++;
		if (got !== exp) begin
			$display("ERR %0t %s got %h exp %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// padr is only meaningful without a fault
	task automatic check_result(input string name, input ptw_result_t got,
		input ptw_result_t exp);
		checks++;
		if (got.fault !== exp.fault || got.asid !== exp.asid || got.vadr !== exp.vadr ||
			(!exp.fault && got.padr !== exp.padr)) begin
			$display("ERR %0t %s got %h exp %h", $time, name, got, exp);
			errors++;
		end
	endtask

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = seed;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		seed = x;
		return x;
	endfunction

	function automatic pte_t mk_pte(input ppn_t ppn, input logic s);
		pte_t p;
		p = '0;
		p.leaf.ppn = ppn;
		p.leaf.s = s;
		p.leaf.r = 1'b1;
		p.leaf.v = 1'b1;
		return p;
	endfunction

	function automatic padr_t root_adr(input vadr_t adr);
		if (m_cfg.lvl)
			return {m_cfg.base, 13'b0} + padr_t'({adr[31:23], 3'b000});
		return {m_cfg.base, 13'b0} + padr_t'({adr[22:13], 3'b000});
	endfunction

	function automatic int lowest_ready();
		for (int i = 0; i < MISSQ_SIZE; i++)
			if (mq[i].v && mq[i].cmt)
				return i;
		return -1;
	endfunction

	// ==============================
	// drive tasks
	// ==============================

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic write_cfg(input ppn_t base, input logic lvl);
		cfg_we = 1'b1;
		cfg_wdata.base = base;
		cfg_wdata.lvl = lvl;
		tick();
		cfg_we = 1'b0;
		m_cfg = cfg_wdata;
	endtask

	task automatic send_miss(input asid_t asid, input vadr_t adr, input rob_id_t id);
		logic dup;
		int slot;
		dup = 1'b0;
		slot = -1;
		for (int i = MISSQ_SIZE - 1; i >= 0; i--) begin
			if (mq[i].v && mq[i].asid == asid && mq[i].adr == adr)
				dup = 1'b1;
			if (!mq[i].v)
				slot = i;
		end
		miss_v = 1'b1;
		miss_asid = asid;
		miss_adr = adr;
		miss_id = id;
		tick();
		miss_v = 1'b0;
		check_bit("in_que", in_que, dup);
		if (!dup && slot >= 0) begin
			mq[slot] = '{v: 1'b1, cmt: 1'b0, lvl: m_cfg.lvl, asid: asid, id: id,
				adr: adr, tadr: root_adr(adr)};
		end
	endtask

	task automatic send_commit(input rob_id_t id);
		commit_v = 1'b1;
		commit_id = id;
		tick();
		commit_v = 1'b0;
		for (int i = 0; i < MISSQ_SIZE; i++)
			if (mq[i].v && mq[i].id == id)
				mq[i].cmt = 1'b1;
	endtask

	task automatic send_flush(input rob_id_t id);
		flush_v = 1'b1;
		flush_id = id;
		tick();
		flush_v = 1'b0;
		for (int i = 0; i < MISSQ_SIZE; i++)
			if (mq[i].v && mq[i].id == id)
				mq[i] = '0;
	endtask

	// waits for the next read and checks it picked the lowest committed entry
	task automatic take_req(output tag_t tag, output padr_t adr);
		int exp;
		while (req_tag_q.size() == 0)
			tick();
		tag = req_tag_q.pop_front();
		adr = req_adr_q.pop_front();
		exp = lowest_ready();
		if (exp < 0) begin
			$display("%0t table read issued with no committed entry", $time);
			errors++;
		end else begin
			check_tag("walk_tag", tag, tag_t'(exp));
			check_padr("walk_adr", adr, mq[exp].tadr);
		end
	endtask

	// memory responder, applies the walk rule to the model entry
	task automatic answer(input tag_t tag, input padr_t adr, input int delay);
		logic [63:0] w;
		miss_entry_t e;
		logic fin;
		ptw_result_t exp_res;
		w = mem.exists(adr) ? mem[adr] : 64'd0;
		e = mq[tag];
		repeat (delay) tick();
		pte_v = 1'b1;
		pte_tag = tag;
		pte = w;
		tick();
		pte_v = 1'b0;
		exp_res = '{fault: !w[0], asid: e.asid, vadr: e.adr, padr: '0};
		fin = 1'b1;
		if (w[0] && e.lvl && !w[1]) begin
			fin = 1'b0;
			mq[tag].lvl = 1'b0;
			mq[tag].tadr = {w[63:45], e.adr[22:13], 3'b000};
		end else if (w[0] && e.lvl) begin
			exp_res.padr = {w[63:55], e.adr[22:0]};
		end else if (w[0]) begin
			exp_res.padr = {w[63:45], e.adr[12:0]};
		end
		check_bit("done", done, fin);
		if (fin) begin
			check_result("result", result, exp_res);
			mq[tag] = '0;
			exp_done++;
		end
	endtask

	task automatic drain();
		tag_t t;
		padr_t a;
		while (lowest_ready() >= 0) begin
			take_req(t, a);
			answer(t, a, int'(next_rand() % 4));
		end
	endtask

	task automatic expect_no_read(input string what);
		repeat (8) tick();
		if (req_tag_q.size() != 0) begin
			$display("%0t table read issued %s", $time, what);
			errors++;
			req_tag_q.delete();
			req_adr_q.delete();
		end
	endtask

	task automatic end_test(input string name);
		expect_no_read("after the walks ended");
		if (done_cnt != exp_done) begin
			$display("%0t %0d completions seen, %0d expected", $time, done_cnt, exp_done);
			errors++;
		end
		$display("test %s: %0d errors", name, errors - err_mark);
		err_mark = errors;
		done_cnt = 0;
		exp_done = 0;
		n_tests++;
	endtask

	// ==============================
	// directed tests
	// ==============================

	task automatic test_two_level();
		vadr_t adr;
		adr = 32'h1234_5678;
		write_cfg(19'h00040, 1'b1);
		mem[root_adr(adr)] = mk_pte(19'h00abc, 1'b0);
		mem[{19'h00abc, adr[22:13], 3'b000}] = mk_pte(19'h05555, 1'b0);
		send_miss(8'h11, adr, 6'd3);
		send_commit(6'd3);
		drain();
		end_test("two_level");
	endtask

	task automatic test_duplicate();
		vadr_t adr;
		adr = 32'h0080_2468;
		mem[root_adr(adr)] = mk_pte(19'h00777, 1'b0);
		mem[{19'h00777, adr[22:13], 3'b000}] = mk_pte(19'h01234, 1'b0);
		send_miss(8'h02, adr, 6'd7);
		send_miss(8'h02, adr, 6'd8);
		send_commit(6'd7);
		// a stored duplicate would start its own walk here
		send_commit(6'd8);
		drain();
		end_test("duplicate");
	endtask

	task automatic test_commit_flush();
		vadr_t adr;
		adr = 32'hc001_d00d;
		mem[root_adr(adr)] = mk_pte(19'h00321, 1'b1);
		send_miss(8'h05, adr, 6'd9);
		expect_no_read("before the commit");
		send_flush(6'd9);
		send_commit(6'd9);
		expect_no_read("for a flushed entry");
		send_miss(8'h05, adr, 6'd10);
		send_commit(6'd10);
		drain();
		end_test("commit_flush");
	endtask

	task automatic test_endings();
		mem[root_adr(32'h4567_89ab)] = mk_pte(19'h7fe00, 1'b1);
		send_miss(8'h21, 32'h4567_89ab, 6'd12);
		send_commit(6'd12);
		drain();
		mem[root_adr(32'h2bad_0000)] = '0;
		send_miss(8'h22, 32'h2bad_0000, 6'd13);
		send_commit(6'd13);
		drain();
		write_cfg(19'h00200, 1'b0);
		mem[root_adr(32'h0066_4321)] = mk_pte(19'h00999, 1'b0);
		send_miss(8'h23, 32'h0066_4321, 6'd14);
		send_commit(6'd14);
		drain();
		write_cfg(19'h00300, 1'b1);
		end_test("endings");
	endtask

	task automatic test_random();
		int order [MISSQ_SIZE];
		int j;
		int tmp;
		logic [31:0] r;
		logic [31:0] a;
		tag_t t;
		padr_t ta;
		for (int round = 0; round < 3; round++) begin
			for (int i = 0; i < MISSQ_SIZE; i++) begin
				r = next_rand();
				a = next_rand();
				send_miss(r[7:0], a, rob_id_t'(20 + i));
				// superpage leaf, or directory to a leaf or an invalid entry
				if (r[8]) begin
					mem[root_adr(a)] = mk_pte(r[31:13], 1'b1);
				end else begin
					mem[root_adr(a)] = mk_pte(r[31:13], 1'b0);
					mem[{r[31:13], a[22:13], 3'b000}] = r[9] ? mk_pte(a[18:0], r[10]) : '0;
				end
				order[i] = i;
			end
			for (int i = MISSQ_SIZE - 1; i > 0; i--) begin
				j = int'(next_rand() % (i + 1));
				tmp = order[i];
				order[i] = order[j];
				order[j] = tmp;
			end
			// the first commit starts a read, the rest queue up behind it
			send_commit(rob_id_t'(20 + order[0]));
			take_req(t, ta);
			for (int i = 1; i < MISSQ_SIZE; i++)
				send_commit(rob_id_t'(20 + order[i]));
			answer(t, ta, int'(next_rand() % 4));
			drain();
		end
		end_test("random");
	endtask

	initial begin
		rst = 1'b1;
		cfg_we = 1'b0;
		cfg_wdata = '0;
		miss_v = 1'b0;
		miss_asid = '0;
		miss_adr = '0;
		miss_id = '0;
		commit_v = 1'b0;
		commit_id = '0;
		flush_v = 1'b0;
		flush_id = '0;
		pte_v = 1'b0;
		pte_tag = '0;
		pte = '0;
		seed = 32'h195afee3;
		m_cfg = '{base: '0, lvl: 1'b1};
		for (int i = 0; i < MISSQ_SIZE; i++)
			mq[i] = '0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		test_two_level();
		test_duplicate();
		test_commit_flush();
		test_endings();
		test_random();
		$display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* tb.f */
verilog/ptw_pkg.sv
verilog/ptw_config.sv
verilog/ptw_queue.sv
verilog/ptw_sched.sv
verilog/ptw_step.sv
verilog/ptw_top.sv
bench/ptw_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f tb.f --top-module ptw_tb -o ptw_sim &&
out=$(./obj_dir/ptw_sim) &&
echo "$out" &&
echo "$out" | grep -q -F '*** TEST PASSED ***' ||
{ echo "simulation did not pass"; exit 1; }
